// File: Bender.yml
package:
  name: wide_narrow_fifo

dependencies: {}

sources:
  - files:
      - src/wfifo_pkg.sv
      - src/fifo_lane_ram.sv
      - src/fifo_write_ctrl.sv
      - src/fifo_read_ctrl.sv
      - src/wide_narrow_fifo.sv
  - target: test
    files:
      - dv/tb_wide_narrow_fifo.sv

// File: dv/fifo_stim.txt
# columns: test write_en read_en wdata expected_byte
# expected_byte is the byte a read pops, -- where no byte is popped
# test 1: reset state, read while empty is ignored
1 0 0 00000000 --
1 0 1 00000000 --
1 0 0 00000000 --
# test 2: byte order of one word
2 1 0 44332211 --
2 0 1 00000000 11
2 0 1 00000000 22
2 0 1 00000000 33
2 0 1 00000000 44
2 0 0 00000000 --
# test 3: fill to full with write rows wrapping, 17th write ignored
3 1 0 03020100 --
3 1 0 07060504 --
3 1 0 0b0a0908 --
3 1 0 0f0e0d0c --
3 1 0 13121110 --
3 1 0 17161514 --
3 1 0 1b1a1918 --
3 1 0 1f1e1d1c --
3 1 0 23222120 --
3 1 0 27262524 --
3 1 0 2b2a2928 --
3 1 0 2f2e2d2c --
3 1 0 33323130 --
3 1 0 37363534 --
3 1 0 3b3a3938 --
3 1 0 3f3e3d3c --
3 1 0 deadbeef --
3 0 0 00000000 --
# test 4: write blocked while full, read frees space, then write and read together
4 0 1 00000000 00
4 0 1 00000000 01
4 0 1 00000000 02
4 1 1 c3c2c1c0 03
4 1 1 d3d2d1d0 04
4 0 0 00000000 --
# test 5: mixed streaming around the full level
5 0 1 00000000 05
5 0 1 00000000 06
5 0 1 00000000 07
5 1 1 e3e2e1e0 08
5 0 1 00000000 09
5 0 1 00000000 0a
5 1 1 99999999 0b
5 1 0 f3f2f1f0 --
5 1 0 88888888 --
5 0 0 00000000 --
# test 6: drain all 64 bytes, read rows wrap, extra reads ignored
6 0 1 00000000 0c
6 0 1 00000000 0d
6 0 1 00000000 0e
6 0 1 00000000 0f
6 0 1 00000000 10
6 0 1 00000000 11
6 0 1 00000000 12
6 0 1 00000000 13
6 0 1 00000000 14
6 0 1 00000000 15
6 0 1 00000000 16
6 0 1 00000000 17
6 0 1 00000000 18
6 0 1 00000000 19
6 0 1 00000000 1a
6 0 1 00000000 1b
6 0 1 00000000 1c
6 0 1 00000000 1d
6 0 1 00000000 1e
6 0 1 00000000 1f
6 0 1 00000000 20
6 0 1 00000000 21
6 0 1 00000000 22
6 0 1 00000000 23
6 0 1 00000000 24
6 0 1 00000000 25
6 0 1 00000000 26
6 0 1 00000000 27
6 0 1 00000000 28
6 0 1 00000000 29
6 0 1 00000000 2a
6 0 1 00000000 2b
6 0 1 00000000 2c
6 0 1 00000000 2d
6 0 1 00000000 2e
6 0 1 00000000 2f
6 0 1 00000000 30
6 0 1 00000000 31
6 0 1 00000000 32
6 0 1 00000000 33
6 0 1 00000000 34
6 0 1 00000000 35
6 0 1 00000000 36
6 0 1 00000000 37
6 0 1 00000000 38
6 0 1 00000000 39
6 0 1 00000000 3a
6 0 1 00000000 3b
6 0 1 00000000 3c
6 0 1 00000000 3d
6 0 1 00000000 3e
6 0 1 00000000 3f
6 0 1 00000000 d0
6 0 1 00000000 d1
6 0 1 00000000 d2
6 0 1 00000000 d3
6 0 1 00000000 e0
6 0 1 00000000 e1
6 0 1 00000000 e2
6 0 1 00000000 e3
6 0 1 00000000 f0
6 0 1 00000000 f1
6 0 1 00000000 f2
6 0 1 00000000 f3
6 0 1 00000000 --
6 0 1 00000000 --

// File: dv/tb_wide_narrow_fifo.sv
`timescale 1ns/1ps

// Testbench for the width converting FIFO
// Vectors come from dv/fifo_stim.txt, one line per clock cycle
module tb_wide_narrow_fifo
  import wfifo_pkg::*;
();

  logic                 clk;
  logic                 rst;
  logic                 write_en;
  logic [WR_DATA_W-1:0] wdata;
  logic                 read_en;
  logic [RD_DATA_W-1:0] rdata;
  logic                 full;
  logic                 empty;
  logic [OCC_W-1:0]     occupancy;

  // Vectors as loaded from the stim file
  int                   vec_test[$];
  bit                   vec_we[$];
  bit                   vec_re[$];
  logic [WR_DATA_W-1:0] vec_wdata[$];
  bit                   vec_has_exp[$];
  logic [RD_DATA_W-1:0] vec_exp[$];
  bit                   vectors_loaded;

  // Byte queue model and the byte rdata should show
  logic [RD_DATA_W-1:0] model_q[$];
  logic [RD_DATA_W-1:0] last_byte;

  int test_errors;
  int tests_passed;
  int tests_failed;

  wide_narrow_fifo u_dut (
    .clk       (clk),
    .rst       (rst),
    .write_en  (write_en),
    .wdata     (wdata),
    .read_en   (read_en),
    .rdata     (rdata),
    .full      (full),
    .empty     (empty),
    .occupancy (occupancy)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  function automatic logic [3:0] hex_digit(input logic [7:0] c);
    if (c >= "0" && c <= "9") begin
      return 4'(c - "0");
    end else if (c >= "a" && c <= "f") begin
      return 4'(c - "a" + 8'd10);
    end else if (c >= "A" && c <= "F") begin
      return 4'(c - "A" + 8'd10);
    end
    return 4'h0;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error: %s is %h, expected %h at %0t", name, got, exp, $time);
      test_errors++;
    end
  endtask

  // Lines that do not hold five fields are comments
  task automatic load_vectors();
    int                   fd;
    int                   n;
    int                   t;
    int                   we;
    int                   re;
    logic [WR_DATA_W-1:0] wd;
    logic [15:0]          tok;
    logic [8*128-1:0]     line;
    fd = $fopen("dv/fifo_stim.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = '0;
        n = $fgets(line, fd);
        if (n > 0) begin
          n = $sscanf(line, "%d %d %d %h %s", t, we, re, wd, tok);
          if (n == 5) begin
            vec_test.push_back(t);
            vec_we.push_back(we != 0);
            vec_re.push_back(re != 0);
            vec_wdata.push_back(wd);
            vec_has_exp.push_back(tok != "--");
            vec_exp.push_back({hex_digit(tok[15:8]), hex_digit(tok[7:0])});
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_outputs();
    check_equal("occupancy", occupancy, model_q.size());
    check_equal("full", full, model_q.size() > BYTE_CAPACITY - LANES);
    check_equal("empty", empty, model_q.size() == 0);
    check_equal("rdata", rdata, last_byte);
  endtask

  // Model update for one cycle, accept decisions use the state before the edge
  task automatic apply_to_model(input int idx);
    bit                   model_full;
    bit                   model_empty;
    logic [RD_DATA_W-1:0] popped;
    model_full  = (model_q.size() > BYTE_CAPACITY - LANES);
    model_empty = (model_q.size() == 0);
    if (vec_re[idx] && !model_empty) begin
      popped = model_q.pop_front();
      assert (vec_has_exp[idx]) else begin
        $display("stim line %0d expects no byte but the model popped one", idx);
        test_errors++;
      end
      if (vec_has_exp[idx]) begin
        check_equal("expected byte", popped, vec_exp[idx]);
      end
      last_byte = popped;
    end else begin
      assert (!vec_has_exp[idx]) else begin
        $display("stim line %0d expects a byte but no read is accepted", idx);
        test_errors++;
      end
    end
    if (vec_we[idx] && !model_full) begin
      for (int b = 0; b < LANES; b++) begin
        model_q.push_back(vec_wdata[idx][b*RD_DATA_W +: RD_DATA_W]);
      end
    end
  endtask

  task automatic report_test(input int num);
    if (test_errors == 0) begin
      $display("test %0d passed", num);
      tests_passed++;
    end else begin
      $display("test %0d failed with %0d errors", num, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial begin
    int cur_test;
    clk       = 1'b0;
    rst       = 1'b1;
    write_en  = 1'b0;
    read_en   = 1'b0;
    wdata     = '0;
    last_byte = '0;
    load_vectors();
    vectors_loaded = 1'b1;
    if (vec_test.size() == 0) begin
      $display("stim file dv/fifo_stim.txt is missing or holds no vectors");
      $display("Done: errors found");
      $finish;
    end else begin
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      cur_test = vec_test[0];
      // One extra idle cycle at the end to see the last read complete
      for (int idx = 0; idx <= vec_test.size(); idx++) begin
        @(posedge clk);
        if (idx < vec_test.size()) begin
          write_en <= vec_we[idx];
          read_en  <= vec_re[idx];
          wdata    <= vec_wdata[idx];
        end else begin
          write_en <= 1'b0;
          read_en  <= 1'b0;
          wdata    <= '0;
        end
        @(negedge clk);
        check_outputs();
        if (idx == vec_test.size()) begin
          report_test(cur_test);
        end else begin
          if (vec_test[idx] != cur_test) begin
            report_test(cur_test);
            cur_test = vec_test[idx];
          end
          apply_to_model(idx);
        end
      end
      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

  // Watchdog, twice the run length plus margin for reset
  initial begin
    wait (vectors_loaded);
    #((vec_test.size() + 20) * 8 * 2);
    $display("timeout: the run did not finish in the expected time");
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: project.f
src/wfifo_pkg.sv
src/fifo_lane_ram.sv
src/fifo_write_ctrl.sv
src/fifo_read_ctrl.sv
src/wide_narrow_fifo.sv
dv/tb_wide_narrow_fifo.sv

// File: src/fifo_lane_ram.sv
`timescale 1ns/1ps

// One byte lane of the FIFO storage
// Simple dual port, write and read rows are independent
module fifo_lane_ram
  import wfifo_pkg::*;
(
  input  logic                  clk,
  input  logic                  wr_en,
  input  logic [ROW_ADDR_W-1:0] wr_addr,
  input  logic [RD_DATA_W-1:0]  wr_data,
  input  logic                  rd_en,
  input  logic [ROW_ADDR_W-1:0] rd_addr,
  output logic [RD_DATA_W-1:0]  rd_data
);

  // Storage array, one byte per row
  logic [RD_DATA_W-1:0] mem [ROW_DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port
  // Output holds its last value while no read is issued
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: src/fifo_read_ctrl.sv
`timescale 1ns/1ps

// Read side of the FIFO
// Bytes come out lane by lane, least significant lane first, then the row steps
module fifo_read_ctrl
  import wfifo_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  read_en,
  input  logic                  empty,
  output logic                  rd_accept,
  output logic [ROW_ADDR_W-1:0] rd_row,
  output logic [LANE_W-1:0]     rd_lane_q
);

  // Lane of the next byte to read
  logic [LANE_W-1:0] lane_cnt;
  logic              lane_last;

  // Reads while empty are dropped
  assign rd_accept = read_en & ~empty;

  assign lane_last = (lane_cnt == LANE_W'(LANES - 1));

  // Lane counter returns to lane zero after the last lane
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      lane_cnt <= '0;
    end else if (rd_accept) begin
      if (lane_last) begin
        lane_cnt <= '0;
      end else begin
        lane_cnt <= lane_cnt + 1'b1;
      end
    end
  end

  // Row pointer moves once the whole row has been consumed
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_row <= '0;
    end else if (rd_accept && lane_last) begin
      rd_row <= rd_row + 1'b1;
    end
  end

  // Lane of the byte loaded into the lane memories on this edge
  // Lines up the output mux with the registered memory outputs
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_lane_q <= '0;
    end else if (rd_accept) begin
      rd_lane_q <= lane_cnt;
    end
  end

  a_no_read_when_empty : assert property (
    @(posedge clk) disable iff (rst)
    empty |-> !rd_accept
  ) else $error("read accepted while empty");

  // Mux select only moves right after an accepted read
  a_lane_q_follows_read : assert property (
    @(posedge clk) disable iff (rst)
    $changed(rd_lane_q) |-> $past(rd_accept)
  ) else $error("rd_lane_q changed without an accepted read");

endmodule

// File: src/fifo_write_ctrl.sv
`timescale 1ns/1ps

// Write side of the FIFO
// One accepted write fills a whole row across all lanes
module fifo_write_ctrl
  import wfifo_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  write_en,
  input  logic                  full,
  output logic                  wr_accept,
  output logic [ROW_ADDR_W-1:0] wr_row
);

  // Writes while full are dropped
  assign wr_accept = write_en & ~full;

  // Row pointer wraps at ROW_DEPTH
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_row <= '0;
    end else if (wr_accept) begin
      wr_row <= wr_row + 1'b1;
    end
  end

  // The row pointer must not move past the read side when the FIFO is full
  a_no_write_when_full : assert property (
    @(posedge clk) disable iff (rst)
    full |-> !wr_accept
  ) else $error("write accepted while full");

endmodule

// File: src/wfifo_pkg.sv
package wfifo_pkg;

  // Write side word width
  localparam int WR_DATA_W = 32;

  // Read side byte width
  localparam int RD_DATA_W = 8;

  // Bytes per written word, one lane memory per byte
  localparam int LANES = WR_DATA_W / RD_DATA_W;

  // Lane index width
  localparam int LANE_W = 2;

  // Row addressing shared by all lanes
  localparam int ROW_ADDR_W = 4;
  localparam int ROW_DEPTH = 1 << ROW_ADDR_W;

  // Total storage in bytes
  localparam int BYTE_CAPACITY = ROW_DEPTH * LANES;

  // Occupancy must reach BYTE_CAPACITY itself, hence one extra bit
  localparam int OCC_W = 7;

endpackage

// File: src/wide_narrow_fifo.sv
`timescale 1ns/1ps

// Width converting FIFO with 32 bit words in and bytes out
// Byte 0 of each word is read first
module wide_narrow_fifo
  import wfifo_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 write_en,
  input  logic [WR_DATA_W-1:0] wdata,
  input  logic                 read_en,
  output logic [RD_DATA_W-1:0] rdata,
  output logic                 full,
  output logic                 empty,
  output logic [OCC_W-1:0]     occupancy
);

  logic                  wr_accept;
  logic [ROW_ADDR_W-1:0] wr_row;
  logic                  rd_accept;
  logic [ROW_ADDR_W-1:0] rd_row;
  logic [LANE_W-1:0]     rd_lane_q;

  // Registered byte of every lane
  logic [RD_DATA_W-1:0] lane_rd_data [LANES];

  // Set by the first accepted read, keeps rdata at zero until then
  logic rd_primed;

  // Byte occupancy grows by a full word per write and shrinks by one byte per read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      occupancy <= '0;
    end else begin
      case ({wr_accept, rd_accept})
        2'b10:   occupancy <= occupancy + OCC_W'(LANES);
        2'b01:   occupancy <= occupancy - 1'b1;
        2'b11:   occupancy <= occupancy + OCC_W'(LANES - 1);
        default: occupancy <= occupancy;
      endcase
    end
  end

  // Full as soon as a whole word no longer fits
  assign full  = (occupancy > OCC_W'(BYTE_CAPACITY - LANES));
  assign empty = (occupancy == '0);

  fifo_write_ctrl u_write_ctrl (
    .clk       (clk),
    .rst       (rst),
    .write_en  (write_en),
    .full      (full),
    .wr_accept (wr_accept),
    .wr_row    (wr_row)
  );

  fifo_read_ctrl u_read_ctrl (
    .clk       (clk),
    .rst       (rst),
    .read_en   (read_en),
    .empty     (empty),
    .rd_accept (rd_accept),
    .rd_row    (rd_row),
    .rd_lane_q (rd_lane_q)
  );

  // One lane memory per byte of the write word
  // All lanes share the same write and read rows
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    fifo_lane_ram u_lane_ram (
      .clk     (clk),
      .wr_en   (wr_accept),
      .wr_addr (wr_row),
      .wr_data (wdata[i*RD_DATA_W +: RD_DATA_W]),
      .rd_en   (rd_accept),
      .rd_addr (rd_row),
      .rd_data (lane_rd_data[i])
    );
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_primed <= 1'b0;
    end else if (rd_accept) begin
      rd_primed <= 1'b1;
    end
  end

  // Output byte mux whose select was registered on the same edge as the lane data
  always_comb begin
    if (rd_primed) begin
      rdata = lane_rd_data[rd_lane_q];
    end else begin
      rdata = '0;
    end
  end

  a_occ_bound : assert property (
    @(posedge clk) disable iff (rst)
    occupancy <= OCC_W'(BYTE_CAPACITY)
  ) else $error("occupancy %0d above capacity", occupancy);

endmodule
